// File: verilog/dvi_init_pkg.sv
package dvi_init_pkg;

    ////////////////////////////////////////
    // table and frame sizes
    ////////////////////////////////////////

    // five register writes per configuration pass
    localparam int REG_COUNT = 5;
    localparam int REG_IDX_W = $clog2(REG_COUNT);

    // addr, wr, ack, reg, ack, data, ack, stop
    localparam int FRAME_SLOTS = 28;

    ////////////////////////////////////////
    // shared types
    ////////////////////////////////////////

    // one register write on the bus
    typedef struct packed {
        logic [6:0] slave_addr;
        logic [7:0] reg_addr;
        logic [7:0] data;
    } dvi_frame_t;

    // sequencer walking the table
    typedef enum logic [1:0] {
        seq_idle,
        seq_launch,
        seq_busy,
        seq_finish
    } seq_state_e;

    // bus phases of one frame
    typedef enum logic [2:0] {
        bit_idle,
        bit_init,
        bit_start,
        bit_clk_fall,
        bit_setup,
        bit_clk_rise,
        bit_wait
    } bit_state_e;

endpackage

// File: verilog/dvi_reg_table.sv
module dvi_reg_table #(
    parameter logic [6:0] I2C_SLAVE_ADDR = 7'h76
) (
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  logic                                 mode_sel,
    input  logic                                 load_mode,
    input  logic [dvi_init_pkg::REG_IDX_W-1:0]   reg_index,
    output dvi_init_pkg::dvi_frame_t             entry
);

    ////////////////////////////////////////
    // register contents
    ////////////////////////////////////////

    // entry 0 sits in the low byte
    localparam logic [dvi_init_pkg::REG_COUNT-1:0][7:0] REG_ADDR =
        {8'h36, 8'h34, 8'h33, 8'h21, 8'h49};

    // variant a is the default after reset
    localparam logic [dvi_init_pkg::REG_COUNT-1:0][7:0] DATA_A =
        {8'ha0, 8'h26, 8'h06, 8'h09, 8'hc0};

    // variant b differs only in the last three
    localparam logic [dvi_init_pkg::REG_COUNT-1:0][7:0] DATA_B =
        {8'h60, 8'h16, 8'h08, 8'h09, 8'hc0};

    // latched variant held for a whole pass
    logic variant_b;

    ////////////////////////////////////////
    // variant latch
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            variant_b <= 1'b0;
        else if (load_mode)
            // mode_sel only matters at the start of a pass
            variant_b <= mode_sel;
    end

    // combinational entry lookup
    always_comb
    begin
        entry.slave_addr = I2C_SLAVE_ADDR;
        entry.reg_addr   = 8'h00;
        entry.data       = 8'h00;
        if (reg_index < dvi_init_pkg::REG_IDX_W'(dvi_init_pkg::REG_COUNT))
        begin
            entry.reg_addr = REG_ADDR[reg_index];
            // data from the variant picked at load time
            entry.data     = variant_b ? DATA_B[reg_index] : DATA_A[reg_index];
        end
    end

endmodule

// File: verilog/i2c_bit_engine.sv
module i2c_bit_engine #(
    parameter int CLK_RATE_MHZ  = 25,
    parameter int SCL_PERIOD_US = 30
) (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     frame_start,
    input  dvi_init_pkg::dvi_frame_t frame,
    output logic                     scl_low,
    output logic                     sda_low,
    output logic                     frame_done
);

    // clocks per phase minus one
    localparam int HALF_PERIOD = (CLK_RATE_MHZ * SCL_PERIOD_US) / 2;
    localparam int PHASE_W     = (HALF_PERIOD > 0) ? $clog2(HALF_PERIOD + 1) : 1;
    localparam int SLOT_W      = $clog2(dvi_init_pkg::FRAME_SLOTS);
    localparam int SLOT_MSB    = dvi_init_pkg::FRAME_SLOTS - 1;

    dvi_init_pkg::bit_state_e state;
    logic [PHASE_W-1:0]       phase_cnt;
    logic [SLOT_W-1:0]        slot_cnt;
    logic [SLOT_MSB:0]        shift_reg;
    logic                     phase_end;
    logic                     last_slot;
    logic                     stop_point;

    assign phase_end  = (phase_cnt == PHASE_W'(HALF_PERIOD));
    assign last_slot  = (slot_cnt == SLOT_W'(SLOT_MSB));
    // sda release point inside the last clk_rise
    assign stop_point = last_slot && (phase_cnt == PHASE_W'(HALF_PERIOD / 2));
    assign frame_done = (state == dvi_init_pkg::bit_wait) && phase_end;

    ////////////////////////////////////////
    // phase and slot counters
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            phase_cnt <= '0;
            slot_cnt  <= '0;
        end
        else
        begin
            // counter parked at zero while idle
            if (state == dvi_init_pkg::bit_idle || phase_end)
                phase_cnt <= '0;
            else
                phase_cnt <= phase_cnt + 1'b1;
            if (state == dvi_init_pkg::bit_idle)
                slot_cnt <= '0;
            else if (state == dvi_init_pkg::bit_clk_rise && phase_end && !last_slot)
                slot_cnt <= slot_cnt + 1'b1;
        end
    end

    // frame image with the msb sent first
    always_ff @(posedge clk)
    begin
        if (state == dvi_init_pkg::bit_idle && frame_start)
            shift_reg <= {frame.slave_addr, 1'b0, 1'b1, frame.reg_addr, 1'b1,
                          frame.data, 1'b1, 1'b0};
        else if (state == dvi_init_pkg::bit_setup && phase_end)
            shift_reg <= {shift_reg[SLOT_MSB-1:0], 1'b0};
    end

    ////////////////////////////////////////
    // phase FSM and pin drive
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            state   <= dvi_init_pkg::bit_idle;
            scl_low <= 1'b0;
            sda_low <= 1'b0;
        end
        else
        begin
            case (state)
                dvi_init_pkg::bit_idle:
                begin
                    // bus released between frames
                    scl_low <= 1'b0;
                    sda_low <= 1'b0;
                    if (frame_start)
                        state <= dvi_init_pkg::bit_init;
                end
                dvi_init_pkg::bit_init:
                    if (phase_end)
                    begin
                        // sda falls with scl high for the start condition
                        sda_low <= 1'b1;
                        state   <= dvi_init_pkg::bit_start;
                    end
                dvi_init_pkg::bit_start:
                    if (phase_end)
                        state <= dvi_init_pkg::bit_clk_fall;
                dvi_init_pkg::bit_clk_fall:
                begin
                    scl_low <= 1'b1;
                    if (phase_end)
                        state <= dvi_init_pkg::bit_setup;
                end
                dvi_init_pkg::bit_setup:
                begin
                    // next slot bit changes only with scl low
                    sda_low <= ~shift_reg[SLOT_MSB];
                    if (phase_end)
                        state <= dvi_init_pkg::bit_clk_rise;
                end
                dvi_init_pkg::bit_clk_rise:
                begin
                    scl_low <= 1'b0;
                    // stop condition halfway through the last high phase
                    if (stop_point)
                        sda_low <= 1'b0;
                    if (phase_end)
                        state <= last_slot ? dvi_init_pkg::bit_wait
                                           : dvi_init_pkg::bit_clk_fall;
                end
                dvi_init_pkg::bit_wait:
                    if (phase_end)
                        state <= dvi_init_pkg::bit_idle;
                default:
                    state <= dvi_init_pkg::bit_idle;
            endcase
        end
    end

    // data edges only under scl low apart from start and stop
    assert property (@(posedge clk) disable iff (!reset_n)
        $changed(sda_low) |-> scl_low
            || ($past(state) == dvi_init_pkg::bit_init && sda_low)
            || ($past(state) == dvi_init_pkg::bit_clk_rise && $past(stop_point)
                && !sda_low));

endmodule

// File: verilog/dvi_init_sequencer.sv
module dvi_init_sequencer (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               init_iic_xfer,
    input  logic                               frame_done,
    input  dvi_init_pkg::dvi_frame_t           entry,
    output logic [dvi_init_pkg::REG_IDX_W-1:0] reg_index,
    output logic                               load_mode,
    output logic                               frame_start,
    output dvi_init_pkg::dvi_frame_t           frame,
    output logic                               iic_xfer_done,
    output logic                               done
);

    dvi_init_pkg::seq_state_e state;
    // set by reset for the automatic first pass
    logic start_pending;
    logic seq_go;
    logic last_entry;

    // requests only count in idle
    assign seq_go     = (state == dvi_init_pkg::seq_idle) && (start_pending || init_iic_xfer);
    assign load_mode  = seq_go;
    assign last_entry = (reg_index ==
                         dvi_init_pkg::REG_IDX_W'(dvi_init_pkg::REG_COUNT - 1));

    ////////////////////////////////////////
    // table walk
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            state         <= dvi_init_pkg::seq_idle;
            start_pending <= 1'b1;
            reg_index     <= '0;
            frame_start   <= 1'b0;
            iic_xfer_done <= 1'b0;
            done          <= 1'b0;
        end
        else
        begin
            // strobes default low
            frame_start   <= 1'b0;
            iic_xfer_done <= 1'b0;
            case (state)
                dvi_init_pkg::seq_idle:
                    if (seq_go)
                    begin
                        start_pending <= 1'b0;
                        reg_index     <= '0;
                        done          <= 1'b0;
                        state         <= dvi_init_pkg::seq_launch;
                    end
                dvi_init_pkg::seq_launch:
                begin
                    // frame registered in this same cycle
                    frame_start <= 1'b1;
                    state       <= dvi_init_pkg::seq_busy;
                end
                dvi_init_pkg::seq_busy:
                    if (frame_done)
                    begin
                        if (last_entry)
                        begin
                            iic_xfer_done <= 1'b1;
                            done          <= 1'b1;
                            state         <= dvi_init_pkg::seq_finish;
                        end
                        else
                        begin
                            reg_index <= reg_index + 1'b1;
                            state     <= dvi_init_pkg::seq_launch;
                        end
                    end
                dvi_init_pkg::seq_finish:
                    state <= dvi_init_pkg::seq_idle;
                default:
                    state <= dvi_init_pkg::seq_idle;
            endcase
        end
    end

    // frame held for the engine until the next launch
    always_ff @(posedge clk)
    begin
        if (state == dvi_init_pkg::seq_launch)
            frame <= entry;
    end

    // one frame in flight at a time
    assert property (@(posedge clk) disable iff (!reset_n)
        frame_start |=> (!frame_start throughout frame_done[->1]));

    assert property (@(posedge clk) disable iff (!reset_n)
        reg_index < dvi_init_pkg::REG_IDX_W'(dvi_init_pkg::REG_COUNT));

endmodule

// File: verilog/dvi_ifc.sv
module dvi_ifc #(
    parameter logic [6:0] I2C_SLAVE_ADDR = 7'h76,
    parameter int         CLK_RATE_MHZ   = 25,
    parameter int         SCL_PERIOD_US  = 30
) (
    input  logic clk,
    input  logic reset_n,
    input  logic init_iic_xfer,
    input  logic mode_sel,
    inout  wire  sda,
    inout  wire  scl,
    output logic iic_xfer_done,
    output logic done
);

    logic [dvi_init_pkg::REG_IDX_W-1:0] reg_index;
    logic                               load_mode;
    logic                               frame_start;
    logic                               frame_done;
    logic                               scl_low;
    logic                               sda_low;
    dvi_init_pkg::dvi_frame_t           entry;
    dvi_init_pkg::dvi_frame_t           frame;

    ////////////////////////////////////////
    // table, sequencer, engine
    ////////////////////////////////////////

    dvi_reg_table #(
        .I2C_SLAVE_ADDR (I2C_SLAVE_ADDR)
    ) i_dvi_reg_table (
        .clk       (clk),
        .reset_n   (reset_n),
        .mode_sel  (mode_sel),
        .load_mode (load_mode),
        .reg_index (reg_index),
        .entry     (entry)
    );

    dvi_init_sequencer i_dvi_init_sequencer (
        .clk           (clk),
        .reset_n       (reset_n),
        .init_iic_xfer (init_iic_xfer),
        .frame_done    (frame_done),
        .entry         (entry),
        .reg_index     (reg_index),
        .load_mode     (load_mode),
        .frame_start   (frame_start),
        .frame         (frame),
        .iic_xfer_done (iic_xfer_done),
        .done          (done)
    );

    i2c_bit_engine #(
        .CLK_RATE_MHZ  (CLK_RATE_MHZ),
        .SCL_PERIOD_US (SCL_PERIOD_US)
    ) i_i2c_bit_engine (
        .clk         (clk),
        .reset_n     (reset_n),
        .frame_start (frame_start),
        .frame       (frame),
        .scl_low     (scl_low),
        .sda_low     (sda_low),
        .frame_done  (frame_done)
    );

    // open drain where a one floats to the pullup
    assign scl = scl_low ? 1'b0 : 1'bz;
    assign sda = sda_low ? 1'b0 : 1'bz;

endmodule

// File: tests/i2c_bus_monitor.sv
module i2c_bus_monitor (
    input  logic reset_n,
    input  wire  scl,
    input  wire  sda,
    output logic violation
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SLOTS = dvi_init_pkg::FRAME_SLOTS;

    // one decoded write as seen on the wires
    typedef struct packed {
        logic [6:0] slave_addr;
        logic       rw;
        logic [7:0] reg_addr;
        logic [7:0] data;
    } bus_frame_t;

    bus_frame_t       frame_q[$];
    int               stop_count = 0;
    logic             in_frame = 1'b0;
    int               slot_count = 0;
    logic [SLOTS-1:0] slots = '0;

    initial
    begin
        violation = 1'b0;
    end

    task automatic flag_violation(input string what);
        $display("bus protocol violation at %0t: %s", $time, what);
        violation = 1'b1;
    endtask

    // slot image msb first as addr, rw, ack, reg, ack, data, ack, stop
    task automatic close_frame();
        bus_frame_t f;
        if (!slots[19] || !slots[10] || !slots[1])
            flag_violation("an ack slot was driven low by the master");
        f.slave_addr = slots[27:21];
        f.rw         = slots[20];
        f.reg_addr   = slots[18:11];
        f.data       = slots[9:2];
        frame_q.push_back(f);
        stop_count = stop_count + 1;
        in_frame   = 1'b0;
    endtask

    ////////////////////////////////////////
    // start and stop detection
    ////////////////////////////////////////

    // sda falling with scl high
    always @(negedge sda)
    begin
        if (reset_n === 1'b1 && scl === 1'b1)
        begin
            if (in_frame)
                flag_violation("SDA fell while SCL was high inside a frame");
            else
            begin
                in_frame   = 1'b1;
                slot_count = 0;
                slots      = '0;
            end
        end
    end

    // sda rising with scl high is only legal after the last slot
    always @(posedge sda)
    begin
        if (reset_n === 1'b1 && scl === 1'b1)
        begin
            if (!in_frame || slot_count != SLOTS)
                flag_violation("SDA rose while SCL was high outside a stop condition");
            else
                close_frame();
        end
    end

    ////////////////////////////////////////
    // slot capture
    ////////////////////////////////////////

    always @(posedge scl)
    begin
        if (reset_n === 1'b1 && in_frame)
        begin
            if (slot_count == SLOTS)
                flag_violation("too many clock pulses before the stop condition");
            else
            begin
                slots      = {slots[SLOTS-2:0], sda};
                slot_count = slot_count + 1;
            end
        end
    end

endmodule

// File: tests/tb_dvi_ifc.sv
module tb_dvi_ifc;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [6:0] SLAVE_ADDR    = 7'h76;
    localparam int         CLK_RATE_MHZ  = 2;
    localparam int         SCL_PERIOD_US = 4;
    // clocks per phase is HALF_PERIOD + 1
    localparam int HALF_PERIOD  = (CLK_RATE_MHZ * SCL_PERIOD_US) / 2;
    localparam int FRAME_PHASES = 3 * dvi_init_pkg::FRAME_SLOTS + 3;
    localparam int FRAME_CYCLES = FRAME_PHASES * (HALF_PERIOD + 1);
    localparam int SEQ_CYCLES   = dvi_init_pkg::REG_COUNT * FRAME_CYCLES;
    // three sequences plus gaps and the final quiet check
    localparam int TIMEOUT_CYCLES = 3 * SEQ_CYCLES + 3 * FRAME_CYCLES + 1000;

    typedef struct packed {
        logic [6:0] slave_addr;
        logic       rw;
        logic [7:0] reg_addr;
        logic [7:0] data;
    } bus_frame_t;

    logic        clk;
    logic        reset_n;
    logic        init_iic_xfer;
    logic        mode_sel;
    wire         sda;
    wire         scl;
    logic        iic_xfer_done;
    logic        done;
    logic        monitor_violation;
    int          cycle_count = 0;
    int          xfer_done_count = 0;
    logic [31:0] rng_state = 32'hbb80_cc73;

    pullup (sda);
    pullup (scl);

    dvi_ifc #(
        .I2C_SLAVE_ADDR (SLAVE_ADDR),
        .CLK_RATE_MHZ   (CLK_RATE_MHZ),
        .SCL_PERIOD_US  (SCL_PERIOD_US)
    ) i_dvi_ifc (
        .clk           (clk),
        .reset_n       (reset_n),
        .init_iic_xfer (init_iic_xfer),
        .mode_sel      (mode_sel),
        .sda           (sda),
        .scl           (scl),
        .iic_xfer_done (iic_xfer_done),
        .done          (done)
    );

    i2c_bus_monitor i_monitor (
        .reset_n   (reset_n),
        .scl       (scl),
        .sda       (sda),
        .violation (monitor_violation)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("MISMATCH time=%0t %s got=%0h expected=%0h", $time, name, got, expected);
            abort_run();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic int random_gap(input int base);
        rng_state = xorshift32(rng_state);
        return base + int'(rng_state[5:0]);
    endfunction

    // expected register map
    function automatic logic [7:0] expected_reg(input int idx);
        case (idx)
            0: return 8'h49;
            1: return 8'h21;
            2: return 8'h33;
            3: return 8'h34;
            default: return 8'h36;
        endcase
    endfunction

    // last three entries differ between variants
    function automatic logic [7:0] expected_data(input int idx, input logic variant_b);
        case (idx)
            0: return 8'hc0;
            1: return 8'h09;
            2: return variant_b ? 8'h08 : 8'h06;
            3: return variant_b ? 8'h16 : 8'h26;
            default: return variant_b ? 8'h60 : 8'ha0;
        endcase
    endfunction

    // cycle budget
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, the sequence never finished", cycle_count);
            abort_run();
        end
    end

    always @(posedge clk)
    begin
        if (reset_n === 1'b1 && iic_xfer_done === 1'b1)
            xfer_done_count <= xfer_done_count + 1;
    end

    always @(posedge monitor_violation)
    begin
        $display("the bus monitor saw an illegal SDA/SCL sequence");
        abort_run();
    end

    task automatic pulse_request(input logic mode);
        @(posedge clk);
        init_iic_xfer <= 1'b1;
        mode_sel      <= mode;
        @(posedge clk);
        init_iic_xfer <= 1'b0;
    endtask

    // done must stay low until the completion strobe
    task automatic wait_sequence_end(input int stops_before);
        @(posedge clk);
        while (iic_xfer_done !== 1'b1)
        begin
            check_value("done", done, 1'b0);
            @(posedge clk);
        end
        check_value("done", done, 1'b1);
        check_value("stop_count", i_monitor.stop_count,
                    stops_before + dvi_init_pkg::REG_COUNT);
    endtask

    task automatic idle_gap(input int cycles);
        repeat (cycles)
        begin
            @(posedge clk);
            check_value("done", done, 1'b1);
            check_value("iic_xfer_done", iic_xfer_done, 1'b0);
        end
    endtask

    task automatic check_frames(input logic variant_b);
        bus_frame_t got;
        check_value("frame_count", i_monitor.frame_q.size(), dvi_init_pkg::REG_COUNT);
        for (int i = 0; i < dvi_init_pkg::REG_COUNT; i++)
        begin
            got = i_monitor.frame_q.pop_front();
            check_value($sformatf("frame[%0d].slave_addr", i), got.slave_addr, SLAVE_ADDR);
            check_value($sformatf("frame[%0d].rw", i), got.rw, 1'b0);
            check_value($sformatf("frame[%0d].reg_addr", i), got.reg_addr, expected_reg(i));
            check_value($sformatf("frame[%0d].data", i), got.data,
                        expected_data(i, variant_b));
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic test_reset_values();
        repeat (2) @(posedge clk);
        check_value("scl", scl, 1'b1);
        check_value("sda", sda, 1'b1);
        check_value("done", done, 1'b0);
        check_value("iic_xfer_done", iic_xfer_done, 1'b0);
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
    endtask

    // pass started by reset alone
    task automatic test_auto_sequence();
        wait_sequence_end(0);
        check_frames(1'b0);
        idle_gap(random_gap(10));
        check_value("xfer_done_count", xfer_done_count, 1);
    endtask

    // variant b with mode flips and stray requests spread over the pass
    task automatic test_mode_b_request();
        int stops_before;
        int count_before;
        stops_before = i_monitor.stop_count;
        count_before = xfer_done_count;
        pulse_request(1'b1);
        mode_sel <= 1'b0;
        repeat (3)
        begin
            // about one frame apart so later entries launch with mode_sel low
            repeat (random_gap(FRAME_CYCLES)) @(posedge clk);
            init_iic_xfer <= 1'b1;
            mode_sel      <= 1'b1;
            @(posedge clk);
            init_iic_xfer <= 1'b0;
            mode_sel      <= 1'b0;
        end
        wait_sequence_end(stops_before);
        check_frames(1'b1);
        idle_gap(random_gap(10));
        check_value("xfer_done_count", xfer_done_count, count_before + 1);
    endtask

    // back to variant a and then a quiet bus
    task automatic test_mode_a_request();
        int stops_before;
        int count_before;
        stops_before = i_monitor.stop_count;
        count_before = xfer_done_count;
        pulse_request(1'b0);
        wait_sequence_end(stops_before);
        check_frames(1'b0);
        idle_gap(FRAME_CYCLES);
        check_value("frame_count", i_monitor.frame_q.size(), 0);
        check_value("xfer_done_count", xfer_done_count, count_before + 1);
    endtask

    initial
    begin
        reset_n       = 1'b0;
        init_iic_xfer = 1'b0;
        mode_sel      = 1'b0;
        test_reset_values();
        test_auto_sequence();
        test_mode_b_request();
        test_mode_a_request();
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: dvi_ifc.f
verilog/dvi_init_pkg.sv
verilog/dvi_reg_table.sv
verilog/i2c_bit_engine.sv
verilog/dvi_init_sequencer.sv
verilog/dvi_ifc.sv
tests/i2c_bus_monitor.sv
tests/tb_dvi_ifc.sv

// File: Bender.yml
package:
  name: dvi_ifc

sources:
  - verilog/dvi_init_pkg.sv
  - verilog/dvi_reg_table.sv
  - verilog/i2c_bit_engine.sv
  - verilog/dvi_init_sequencer.sv
  - verilog/dvi_ifc.sv
  - target: test
    files:
      - tests/i2c_bus_monitor.sv
      - tests/tb_dvi_ifc.sv
